// ==== Bender.yml ====
package:
  name: am4_irq_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/am4_cpu_pkg.sv
      - verilog/am4_bus_pkg.sv
      - verilog/am4_apb_slave.sv
      - verilog/am4_irq_ctrl.sv
      - verilog/am4_branch_cond.sv
      - verilog/am4_irq_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_am4_irq_unit.sv

// ==== am4_irq_unit.f ====
+incdir+verilog
verilog/am4_cpu_pkg.sv
verilog/am4_bus_pkg.sv
verilog/am4_apb_slave.sv
verilog/am4_irq_ctrl.sv
verilog/am4_branch_cond.sv
verilog/am4_irq_unit.sv
dv/tb_am4_irq_unit.sv

// ==== dv/tb_am4_irq_unit.sv ====
//**********************************************************
// am4 interrupt unit testbench: clock, reset, APB tasks,
// LFSR, reference models, compare tasks and tests
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "am4_settings.svh"

module tb_am4_irq_unit;

   import am4_cpu_pkg::*;
   import am4_bus_pkg::*;

   localparam int CLK_PERIOD = 100;                   // ns
   localparam int WAIT_MAX   = 10;                    // cycles per wait
   localparam logic [`AM4_APB_AW-1:0] A_PSW  = `AM4_APB_AW'(`AM4_OFS_PSW);
   localparam logic [`AM4_APB_AW-1:0] A_IREG = `AM4_APB_AW'(`AM4_OFS_IREG);
   localparam logic [`AM4_APB_AW-1:0] A_CMD  = `AM4_APB_AW'(`AM4_OFS_CMD);
   localparam logic [`AM4_APB_AW-1:0] A_STAT = `AM4_APB_AW'(`AM4_OFS_STAT);

   logic                   pin_clk;
   logic                   dclo;
   logic                   psel_i;
   logic                   penable_i;
   logic                   pwrite_i;
   logic [`AM4_APB_AW-1:0] paddr_i;
   logic [`AM4_APB_DW-1:0] pwdata_i;
   logic                   aclo_n_i;
   logic                   evnt_n_i;
   logic                   rfrq_n_i;
   logic                   halt_n_i;
   logic                   virq_n_i;
   logic [`AM4_APB_DW-1:0] prdata_o;
   irq_vec_t               irq_vec_o;
   logic                   irq_pend_o;
   logic                   bra_taken_o;
   logic                   dref_n_o;

   logic [31:0] lfsr_q = 32'h3007;                    // random source state
   string       cur_test = "reset";
   int          vec_errs = 0;
   int          bit_errs = 0;
   int          word_errs = 0;
   int          tmo_errs = 0;

   am4_irq_unit am4_irq_unit_i
   (
      .pin_clk     (pin_clk),
      .dclo        (dclo),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .aclo_n_i    (aclo_n_i),
      .evnt_n_i    (evnt_n_i),
      .rfrq_n_i    (rfrq_n_i),
      .halt_n_i    (halt_n_i),
      .virq_n_i    (virq_n_i),
      .prdata_o    (prdata_o),
      .irq_vec_o   (irq_vec_o),
      .irq_pend_o  (irq_pend_o),
      .bra_taken_o (bra_taken_o),
      .dref_n_o    (dref_n_o)
   );

   initial
   begin
      pin_clk = 1'b0;
      forever #(CLK_PERIOD/2) pin_clk = ~pin_clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic get_rand(input int nbits, output logic [15:0] val);
      int i;
      val = '0;
      for (i = 0; i < nbits; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);                  // one step per bit
         val    = {val[14:0], lfsr_q[0]};
      end
   endtask

   // branch table, code is {ir[15], ir[10:8]}
   function automatic logic ref_branch(input psw_t p, input ireg_t ir);
      logic c;
      logic v;
      logic z;
      logic n;
      c = p[0];
      v = p[1];
      z = p[2];
      n = p[3];
      case ({ir[15], ir[10:8]})
         4'd0:  return 1'b0;                          // not a branch
         4'd1:  return 1'b1;                          // br
         4'd2:  return ~z;
         4'd3:  return z;
         4'd4:  return ~(n ^ v);                      // bge
         4'd5:  return n ^ v;
         4'd6:  return ~((n ^ v) | z);                // bgt
         4'd7:  return (n ^ v) | z;
         4'd8:  return ~n;
         4'd9:  return n;
         4'd10: return ~(c | z);                      // bhi
         4'd11: return c | z;
         4'd12: return ~v;
         4'd13: return v;
         4'd14: return ~c;
         default: return c;                           // bcs
      endcase
   endfunction

   // priority rfrq > trace > aclo > halt > evnt > virq
   function automatic irq_vec_t ref_vector(input psw_t p, input logic aclo, input logic evnt,
                                           input logic rfrq, input logic halt, input logic virq);
      if (rfrq)
         return VEC_RFRQ;
      if (p[4])
         return VEC_TRACE;
      if (aclo)
         return VEC_ACLO;
      if (halt)
         return VEC_HALT;
      if (evnt & ~p[7])
         return VEC_EVNT;                             // masked by priority
      if (virq & ~p[7])
         return VEC_VIRQ;
      return VEC_NONE;
   endfunction

   task automatic check_vec(input string what, input irq_vec_t exp, input irq_vec_t act);
      if (act !== exp)
      begin
         vec_errs++;
         $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp)
      begin
         bit_errs++;
         $display("** Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
      end
   endtask

   task automatic check_word(input string what, input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp)
      begin
         word_errs++;
         $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic apb_write(input logic [`AM4_APB_AW-1:0] addr,
                            input logic [`AM4_APB_DW-1:0] data);
      @(negedge pin_clk);
      psel_i    = 1'b1;                               // setup phase
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(negedge pin_clk);
      penable_i = 1'b1;                               // access phase
      @(negedge pin_clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [`AM4_APB_AW-1:0] addr,
                           output logic [`AM4_APB_DW-1:0] data);
      @(negedge pin_clk);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(negedge pin_clk);
      penable_i = 1'b1;
      #(CLK_PERIOD/4);                                // mid access cycle
      data = prdata_o;
      @(negedge pin_clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge pin_clk);
   endtask

   // pending flag is set exactly when some vector is encoded
   task automatic wait_vec(input string what, input irq_vec_t exp);
      int n;
      n = 0;
      while (irq_vec_o !== exp && n < WAIT_MAX)
      begin
         @(negedge pin_clk);
         n++;
      end
      if (irq_vec_o !== exp)
      begin
         tmo_errs++;
         $display("%s: irq vector did not reach the expected code in %0d cycles",
                  cur_test, WAIT_MAX);
      end
      check_vec(what, exp, irq_vec_o);
      check_bit({what, " pending"}, exp != VEC_NONE, irq_pend_o);
   endtask

   initial
   begin
      logic [15:0] rnd;
      logic [15:0] rd;
      psw_t        psw;
      ireg_t       ir;
      logic        exp;
      int          i;
      int          k;
      int          ph;
      dclo      = 1'b1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      aclo_n_i  = 1'b1;                               // all requests idle
      evnt_n_i  = 1'b1;
      rfrq_n_i  = 1'b1;
      halt_n_i  = 1'b1;
      virq_n_i  = 1'b1;
      repeat (8) @(negedge pin_clk);
      dclo = 1'b0;

      apb_read(A_STAT, rd);
      check_word("STAT", 16'h0007, rd);
      check_bit("dref_n_o", 1'b1, dref_n_o);
      check_bit("irq_pend_o", 1'b0, irq_pend_o);
      apb_read(A_PSW, rd);
      check_word("PSW", 16'h0000, rd);
      apb_read(A_IREG, rd);
      check_word("IREG", 16'h0000, rd);

      cur_test = "branch";
      for (i = 0; i < 200; i++)
      begin
         get_rand(8, rnd);
         psw = psw_t'(rnd[7:0]);
         apb_write(A_PSW, 16'(psw));
         for (k = 0; k < 16; k++)
         begin
            get_rand(16, rnd);
            ir = {k[3], rnd[14:11], k[2:0], rnd[7:0]};  // code in 15, 10:8
            apb_write(A_IREG, ir);
            exp = ref_branch(psw, ir);
            check_bit("bra_taken_o", exp, bra_taken_o);
            apb_read(A_STAT, rd);
            check_bit("STAT bit 4", exp, rd[4]);
         end
      end
      apb_write(A_PSW, 16'h0000);

      cur_test = "edge latch";
      aclo_n_i = 1'b0;
      wait_vec("after aclo edge", VEC_ACLO);
      evnt_n_i = 1'b0;
      idle_cycles(4);
      check_vec("after evnt edge", VEC_ACLO, irq_vec_o);   // aclo still wins
      apb_write(A_CMD, 16'(CMD_CLR_ACLO));
      wait_vec("after aclo clear", VEC_EVNT);
      apb_write(A_CMD, 16'(CMD_CLR_EVNT));
      wait_vec("after evnt clear", VEC_NONE);
      idle_cycles(4);
      check_vec("held pins", VEC_NONE, irq_vec_o);      // no relatch

      cur_test = "priority";
      evnt_n_i = 1'b1;
      idle_cycles(2);
      evnt_n_i = 1'b0;                                  // fresh evnt edge
      virq_n_i = 1'b0;
      idle_cycles(4);
      for (ph = 0; ph < 2; ph++)
      begin
         for (k = 0; k < 24; k++)
         begin
            get_rand(8, rnd);
            psw = psw_t'(rnd[7:0]);
            get_rand(1, rnd);
            halt_n_i = ~rnd[0];
            apb_write(A_PSW, 16'(psw));
            idle_cycles(1);
            wait_vec("masked vector",
                     ref_vector(psw, 1'b0, ph == 0, 1'b0, rnd[0], 1'b1));
         end
         apb_write(A_CMD, 16'(CMD_CLR_EVNT));           // second pass without evnt
      end
      halt_n_i = 1'b1;
      virq_n_i = 1'b1;
      apb_write(A_PSW, 16'h0000);
      wait_vec("requests released", VEC_NONE);

      cur_test = "refresh";
      rfrq_n_i = 1'b0;
      wait_vec("after rfrq edge", VEC_RFRQ);
      check_bit("dref_n_o idle", 1'b1, dref_n_o);
      apb_read(A_STAT, rd);
      check_vec("STAT vector", VEC_RFRQ, irq_vec_t'(rd[2:0]));
      check_bit("STAT bit 3", 1'b1, rd[3]);
      apb_write(A_CMD, 16'(CMD_SET_REF));
      wait_vec("after set ref", VEC_NONE);
      check_bit("dref_n_o set", 1'b0, dref_n_o);
      apb_read(A_STAT, rd);
      check_bit("STAT bit 5", 1'b1, rd[5]);
      apb_write(A_CMD, 16'(CMD_CLR_REF));
      idle_cycles(1);
      check_bit("dref_n_o clear", 1'b1, dref_n_o);
      rfrq_n_i = 1'b1;

      cur_test = "read write";
      for (i = 0; i < 20; i++)
      begin
         get_rand(16, rnd);
         apb_write(A_PSW, rnd);
         apb_read(A_PSW, rd);
         check_word("PSW", {8'h00, rnd[7:0]}, rd);      // 8 bit register
         get_rand(16, rnd);
         apb_write(A_IREG, rnd);
         apb_read(A_IREG, rd);
         check_word("IREG", rnd, rd);
      end
      apb_write(A_CMD, 16'(CMD_CLR_REF));
      apb_read(A_CMD, rd);
      check_word("CMD", 16'h0000, rd);

      $display("errors: vector %0d, bit %0d, word %0d, timeout %0d",
               vec_errs, bit_errs, word_errs, tmo_errs);
      if (vec_errs + bit_errs + word_errs + tmo_errs == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/am4_apb_slave.sv ====
//**********************************************************
// am4 APB slave: address decode, PSW and IREG registers,
// command strobe and read data mux
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "am4_settings.svh"

module am4_apb_slave
(
   input  wire                         pin_clk,       // main clock
   input  wire                         dclo,          // async reset
   input  wire                         psel_i,        // slave select
   input  wire                         penable_i,     // access phase
   input  wire                         pwrite_i,      // write transfer
   input  wire   [`AM4_APB_AW-1:0]     paddr_i,       // byte address
   input  wire   [`AM4_APB_DW-1:0]     pwdata_i,      // write data
   input  wire   am4_cpu_pkg::irq_vec_t irq_vec_i,    // encoded vector
   input  wire                         irq_pend_i,    // any request
   input  wire                         bra_taken_i,   // branch decision
   input  wire                         dref_i,        // refresh strobe
   output logic  [`AM4_APB_DW-1:0]     prdata_o,      // read data
   output am4_cpu_pkg::psw_t           psw_o,         // status word
   output am4_cpu_pkg::ireg_t          ireg_o,        // instruction
   output logic                        cmd_vld_o,     // one-cycle strobe
   output am4_bus_pkg::cmd_t           cmd_o          // command code
);

   import am4_cpu_pkg::*;
   import am4_bus_pkg::*;

   // STAT register layout above the vector field
   localparam int STAT_PEND = `AM4_VEC_W;            // bit 3
   localparam int STAT_BRA  = `AM4_VEC_W + 1;        // bit 4
   localparam int STAT_DREF = `AM4_VEC_W + 2;        // bit 5

   apb_reg_t  reg_idx;                                // word being accessed
   logic      addr_ok;                                // word aligned
   logic      wr_en;                                  // write, access phase
   logic      cmd_wr;                                 // command accepted
   cmd_t      cmd_new;                                // code on pwdata

   assign reg_idx = apb_reg_t'(paddr_i[`AM4_APB_AW-1:2]);
   assign addr_ok = (paddr_i[1:0] == 2'b00);         // odd bytes ignored
   assign wr_en   = psel_i & penable_i & pwrite_i & addr_ok;
   assign cmd_new = cmd_t'(pwdata_i[$bits(cmd_t)-1:0]);
   assign cmd_wr  = wr_en & (reg_idx == REG_CMD) & (cmd_new != CMD_NOP);

   // host visible registers and command strobe
   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
      begin
         psw_o     <= '0;
         ireg_o    <= '0;
         cmd_vld_o <= 1'b0;
         cmd_o     <= CMD_NOP;
      end
      else
      begin
         cmd_vld_o <= cmd_wr;                         // self clearing
         if (cmd_wr)
            cmd_o <= cmd_new;                         // held with the strobe
         if (wr_en & (reg_idx == REG_PSW))
            psw_o <= psw_t'(pwdata_i[`AM4_PSW_W-1:0]);
         if (wr_en & (reg_idx == REG_IREG))
            ireg_o <= ireg_t'(pwdata_i[`AM4_IREG_W-1:0]);
      end
   end

   // read data, valid through setup and access
   always_comb
   begin
      prdata_o = '0;
      if (psel_i & addr_ok)
         case (reg_idx)
            REG_PSW:  prdata_o[`AM4_PSW_W-1:0]  = psw_o;
            REG_IREG: prdata_o[`AM4_IREG_W-1:0] = ireg_o;
            REG_STAT:
            begin
               prdata_o[`AM4_VEC_W-1:0] = irq_vec_i;  // vector code
               prdata_o[STAT_PEND]      = irq_pend_i;
               prdata_o[STAT_BRA]       = bra_taken_i;
               prdata_o[STAT_DREF]      = dref_i;
            end
            default:  prdata_o = '0;                  // CMD reads zero
         endcase
   end

endmodule

`default_nettype wire

// ==== verilog/am4_branch_cond.sv ====
//**********************************************************
// am4 conditional branch evaluator from IREG and PSW
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module am4_branch_cond
(
   input  wire   am4_cpu_pkg::psw_t    psw_i,         // condition flags
   input  wire   am4_cpu_pkg::ireg_t   ireg_i,        // instruction
   output logic                        bra_taken_o    // branch decision
);

   import am4_cpu_pkg::*;

   bra_code_t code;                                   // branch selector
   logic      flag_c;
   logic      flag_v;
   logic      flag_z;
   logic      flag_n;
   logic      lt;                                     // signed less than

   assign code   = bra_code_t'({ireg_i[15], ireg_i[10:8]});
   assign flag_c = psw_i[PSW_C];
   assign flag_v = psw_i[PSW_V];
   assign flag_z = psw_i[PSW_Z];
   assign flag_n = psw_i[PSW_N];
   assign lt     = flag_n ^ flag_v;

   always_comb
   begin
      case (code)
         BRC_NONE: bra_taken_o = 1'b0;                 // not a branch
         BRC_BR:   bra_taken_o = 1'b1;
         BRC_BNE:  bra_taken_o = ~flag_z;
         BRC_BEQ:  bra_taken_o = flag_z;
         BRC_BGE:  bra_taken_o = ~lt;
         BRC_BLT:  bra_taken_o = lt;
         BRC_BGT:  bra_taken_o = ~(lt | flag_z);
         BRC_BLE:  bra_taken_o = lt | flag_z;
         BRC_BPL:  bra_taken_o = ~flag_n;
         BRC_BMI:  bra_taken_o = flag_n;
         BRC_BHI:  bra_taken_o = ~(flag_c | flag_z);   // unsigned higher
         BRC_BLOS: bra_taken_o = flag_c | flag_z;
         BRC_BVC:  bra_taken_o = ~flag_v;
         BRC_BVS:  bra_taken_o = flag_v;
         BRC_BCC:  bra_taken_o = ~flag_c;
         BRC_BCS:  bra_taken_o = flag_c;
         default:  bra_taken_o = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/am4_bus_pkg.sv ====
//**********************************************************
// am4 host bus types: APB register index and
// command opcodes of the CMD register
//**********************************************************

`default_nettype none

package am4_bus_pkg;

`include "am4_settings.svh"

   // word index, byte offset over 4
   typedef enum logic [1:0] {
      REG_PSW  = 2'(`AM4_OFS_PSW  / 4),     // status word
      REG_IREG = 2'(`AM4_OFS_IREG / 4),     // instruction
      REG_CMD  = 2'(`AM4_OFS_CMD  / 4),     // command strobe
      REG_STAT = 2'(`AM4_OFS_STAT / 4)      // request status
   } apb_reg_t;

   // opcodes written to CMD, bit 2 marks a latch ack
   typedef enum logic [2:0] {
      CMD_NOP      = 3'd0,                   // no action
      CMD_CLR_REF  = 3'd2,                   // drop dref
      CMD_SET_REF  = 3'd3,                   // raise dref, ack rfrq
      CMD_CLR_ACLO = 3'd6,                   // ack power fail
      CMD_CLR_EVNT = 3'd7                    // ack timer event
   } cmd_t;

endpackage

`default_nettype wire

// ==== verilog/am4_cpu_pkg.sv ====
//**********************************************************
// am4 processor architecture types: PSW and IREG words,
// PSW bit positions, branch codes and vector codes
//**********************************************************

`default_nettype none

package am4_cpu_pkg;

`include "am4_settings.svh"

   typedef logic [`AM4_PSW_W-1:0]  psw_t;    // processor status word
   typedef logic [`AM4_IREG_W-1:0] ireg_t;   // instruction word

   // PSW bit positions
   localparam int PSW_C   = 0;               // carry
   localparam int PSW_V   = 1;               // overflow
   localparam int PSW_Z   = 2;               // zero
   localparam int PSW_N   = 3;               // negative
   localparam int PSW_T   = 4;               // trace trap
   localparam int PSW_PRI = 7;               // priority mask

   // {ireg[15], ireg[10:8]} of a branch instruction
   typedef enum logic [3:0] {
      BRC_NONE, BRC_BR,  BRC_BNE, BRC_BEQ,
      BRC_BGE,  BRC_BLT, BRC_BGT, BRC_BLE,
      BRC_BPL,  BRC_BMI, BRC_BHI, BRC_BLOS,
      BRC_BVC,  BRC_BVS, BRC_BCC, BRC_BCS
   } bra_code_t;

   // vector code, lower value wins
   typedef enum logic [`AM4_VEC_W-1:0] {
      VEC_RFRQ  = 3'd0,                      // refresh request
      VEC_TRACE = 3'd1,                      // trace trap
      VEC_ACLO  = 3'd2,                      // power fail
      VEC_HALT  = 3'd3,                      // supervisor halt
      VEC_EVNT  = 3'd4,                      // timer event
      VEC_VIRQ  = 3'd5,                      // vectored interrupt
      VEC_NONE  = 3'd7                       // nothing pending
   } irq_vec_t;

endpackage

`default_nettype wire

// ==== verilog/am4_irq_ctrl.sv ====
//**********************************************************
// am4 interrupt controller: pin sampling, edge latches,
// refresh flip-flop, request register, priority encoder
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module am4_irq_ctrl
(
   input  wire                         pin_clk,       // main clock
   input  wire                         dclo,          // async reset
   input  wire                         aclo_n_i,      // power fail
   input  wire                         evnt_n_i,      // timer event
   input  wire                         rfrq_n_i,      // refresh request
   input  wire                         halt_n_i,      // halt request
   input  wire                         virq_n_i,      // vectored irq
   input  wire   am4_cpu_pkg::psw_t    psw_i,         // status word
   input  wire                         cmd_vld_i,     // command strobe
   input  wire   am4_bus_pkg::cmd_t    cmd_i,         // command code
   output am4_cpu_pkg::irq_vec_t       irq_vec_o,     // encoded vector
   output logic                        irq_pend_o,    // any request
   output logic                        dref_o         // refresh strobe
);

   import am4_cpu_pkg::*;
   import am4_bus_pkg::*;

   // index into the pin sample vector
   localparam int PIN_ACLO = 0;
   localparam int PIN_EVNT = 1;
   localparam int PIN_RFRQ = 2;
   localparam int PIN_HALT = 3;
   localparam int PIN_VIRQ = 4;

   logic [4:0] pin_s;                                 // pins, active high
   logic [2:0] pin_p;                                 // previous edge samples
   logic [2:0] edge_set;                              // new assertion seen
   logic       aclo;                                  // power fail latch
   logic       evnt;                                  // timer latch
   logic       rfrq;                                  // refresh latch
   logic       clr_aclo;
   logic       clr_evnt;
   logic       set_ref;
   logic       clr_ref;
   logic [5:0] irq;                                   // request register

   assign clr_aclo = cmd_vld_i & (cmd_i == CMD_CLR_ACLO);
   assign clr_evnt = cmd_vld_i & (cmd_i == CMD_CLR_EVNT);
   assign set_ref  = cmd_vld_i & (cmd_i == CMD_SET_REF);
   assign clr_ref  = cmd_vld_i & (cmd_i == CMD_CLR_REF);

   // one sample per clock, pins are asynchronous
   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
      begin
         pin_s <= '0;
         pin_p <= '0;
      end
      else
      begin
         pin_s <= ~{virq_n_i, halt_n_i, rfrq_n_i, evnt_n_i, aclo_n_i};
         pin_p <= pin_s[PIN_RFRQ:PIN_ACLO];
      end
   end

   assign edge_set = pin_s[PIN_RFRQ:PIN_ACLO] & ~pin_p;   // held level ignored

   // edge latches and refresh strobe, clear beats set
   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
      begin
         aclo   <= 1'b0;
         evnt   <= 1'b0;
         rfrq   <= 1'b0;
         dref_o <= 1'b0;
      end
      else
      begin
         if (clr_aclo)
            aclo <= 1'b0;
         else if (edge_set[PIN_ACLO])
            aclo <= 1'b1;
         if (clr_evnt)
            evnt <= 1'b0;
         else if (edge_set[PIN_EVNT])
            evnt <= 1'b1;
         if (set_ref)
            rfrq <= 1'b0;                             // refresh taken
         else if (edge_set[PIN_RFRQ])
            rfrq <= 1'b1;
         if (clr_ref)
            dref_o <= 1'b0;
         else if (set_ref)
            dref_o <= 1'b1;
      end
   end

   // request register, reloaded every clock
   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         irq <= '0;
      else
      begin
         irq[0] <= pin_s[PIN_VIRQ] & ~psw_i[PSW_PRI];  // masked by priority
         irq[1] <= evnt & ~psw_i[PSW_PRI];
         irq[2] <= pin_s[PIN_HALT];                    // level request
         irq[3] <= aclo;
         irq[4] <= psw_i[PSW_T];                       // trace trap
         irq[5] <= rfrq;
      end
   end

   // highest bit wins
   always_comb
   begin
      if (irq[5])
         irq_vec_o = VEC_RFRQ;
      else if (irq[4])
         irq_vec_o = VEC_TRACE;
      else if (irq[3])
         irq_vec_o = VEC_ACLO;
      else if (irq[2])
         irq_vec_o = VEC_HALT;
      else if (irq[1])
         irq_vec_o = VEC_EVNT;
      else if (irq[0])
         irq_vec_o = VEC_VIRQ;
      else
         irq_vec_o = VEC_NONE;
   end

   assign irq_pend_o = |irq;

endmodule

`default_nettype wire

// ==== verilog/am4_irq_unit.sv ====
//**********************************************************
// am4 interrupt unit top: APB slave, interrupt controller
// and branch evaluator
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "am4_settings.svh"

module am4_irq_unit
(
   input  wire                         pin_clk,       // main clock
   input  wire                         dclo,          // async reset
   input  wire                         psel_i,        // APB select
   input  wire                         penable_i,     // APB access phase
   input  wire                         pwrite_i,      // APB write
   input  wire   [`AM4_APB_AW-1:0]     paddr_i,       // APB byte address
   input  wire   [`AM4_APB_DW-1:0]     pwdata_i,      // APB write data
   input  wire                         aclo_n_i,      // power fail
   input  wire                         evnt_n_i,      // timer event
   input  wire                         rfrq_n_i,      // refresh request
   input  wire                         halt_n_i,      // halt request
   input  wire                         virq_n_i,      // vectored irq
   output logic  [`AM4_APB_DW-1:0]     prdata_o,      // APB read data
   output am4_cpu_pkg::irq_vec_t       irq_vec_o,     // encoded vector
   output logic                        irq_pend_o,    // any request
   output logic                        bra_taken_o,   // branch decision
   output logic                        dref_n_o       // refresh strobe
);

   import am4_cpu_pkg::*;
   import am4_bus_pkg::*;

   psw_t  psw;                                        // status word
   ireg_t ireg;                                       // instruction
   logic  cmd_vld;                                    // command strobe
   cmd_t  cmd;                                        // command code
   logic  dref;                                       // refresh, active high

   am4_apb_slave am4_apb_slave_i
   (
      .pin_clk     (pin_clk),
      .dclo        (dclo),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .irq_vec_i   (irq_vec_o),
      .irq_pend_i  (irq_pend_o),
      .bra_taken_i (bra_taken_o),
      .dref_i      (dref),
      .prdata_o    (prdata_o),
      .psw_o       (psw),
      .ireg_o      (ireg),
      .cmd_vld_o   (cmd_vld),
      .cmd_o       (cmd)
   );

   am4_irq_ctrl am4_irq_ctrl_i
   (
      .pin_clk     (pin_clk),
      .dclo        (dclo),
      .aclo_n_i    (aclo_n_i),
      .evnt_n_i    (evnt_n_i),
      .rfrq_n_i    (rfrq_n_i),
      .halt_n_i    (halt_n_i),
      .virq_n_i    (virq_n_i),
      .psw_i       (psw),
      .cmd_vld_i   (cmd_vld),
      .cmd_i       (cmd),
      .irq_vec_o   (irq_vec_o),
      .irq_pend_o  (irq_pend_o),
      .dref_o      (dref)
   );

   am4_branch_cond am4_branch_cond_i
   (
      .psw_i       (psw),
      .ireg_i      (ireg),
      .bra_taken_o (bra_taken_o)
   );

   assign dref_n_o = ~dref;                           // pin is active low

endmodule

`default_nettype wire

// ==== verilog/am4_settings.svh ====
//**********************************************************
// am4 interrupt unit: register widths, APB geometry
// and register byte offsets
//**********************************************************

`ifndef AM4_SETTINGS_SVH
`define AM4_SETTINGS_SVH

// processor side widths
`define AM4_PSW_W       8     // processor status word
`define AM4_IREG_W      16    // instruction register
`define AM4_VEC_W       3     // encoded interrupt vector

// APB port geometry
`define AM4_APB_AW      4     // byte address, 4 words
`define AM4_APB_DW      16    // read/write data

// register map, byte offsets
`define AM4_OFS_PSW     0     // status word, r/w
`define AM4_OFS_IREG    4     // instruction, r/w
`define AM4_OFS_CMD     8     // command, write only
`define AM4_OFS_STAT    12    // status, read only

`endif
